// File: design/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);

    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    always_comb begin
        case (1'b1)
            alu_op[alu_add]:  alu_result = alu_src1 + alu_src2;
            alu_op[alu_sub]:  alu_result = alu_src1 - alu_src2;
            alu_op[alu_slt]:  alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            alu_op[alu_sltu]: alu_result = {31'b0, alu_src1 < alu_src2};
            alu_op[alu_and]:  alu_result = alu_src1 & alu_src2;
            alu_op[alu_nor]:  alu_result = ~(alu_src1 | alu_src2);
            alu_op[alu_or]:   alu_result = alu_src1 | alu_src2;
            alu_op[alu_xor]:  alu_result = alu_src1 ^ alu_src2;
            alu_op[alu_sll]:  alu_result = alu_src1 << shamt;
            alu_op[alu_srl]:  alu_result = alu_src1 >> shamt;
            alu_op[alu_sra]:  alu_result = word_t'($signed(alu_src1) >>> shamt);
            // immediate already shifted in decode
            alu_op[alu_lui]:  alu_result = alu_src2;
            default:          alu_result = '0;
        endcase
    end

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // bit positions in the one-hot alu_op vector
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // major opcode in inst[31:26]
    localparam logic [5:0] op_alu   = 6'h00;
    localparam logic [5:0] op_lu12i = 6'h05;
    localparam logic [5:0] op_mem   = 6'h0a;
    localparam logic [5:0] op_jirl  = 6'h13;
    localparam logic [5:0] op_b     = 6'h14;
    localparam logic [5:0] op_bl    = 6'h15;
    localparam logic [5:0] op_beq   = 6'h16;
    localparam logic [5:0] op_bne   = 6'h17;

    localparam reg_addr_t zero_reg = 5'd0;
    localparam reg_addr_t link_reg = 5'd1;

endpackage

// File: design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'h1c00_0000
) (
    input  logic      clk,
    input  logic      reset,
    output word_t     inst_sram_addr,
    input  word_t     inst_sram_rdata,
    output logic      data_sram_en,
    output logic      data_sram_we,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  word_t     data_sram_rdata,
    output word_t     debug_wb_pc,
    output logic      debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    word_t     id_pc;
    logic      id_valid;
    logic      id_ready;
    word_t     inst;
    logic      br_taken;
    word_t     br_target;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rj_value;
    word_t     rkd_value;
    logic      used_rj;
    logic      used_rkd;
    reg_addr_t id_dest;
    logic      id_writes;
    alu_op_t   alu_op;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     store_data;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t ex_fwd_dest;
    logic      ex_fwd_valid;
    word_t     ex_fwd_data;
    word_t     mem_pc;
    reg_addr_t mem_dest;
    word_t     mem_result;
    logic      mem_writes;
    logic      mem_is_load;
    logic      mem_valid;
    reg_addr_t mem_fwd_dest;
    logic      mem_fwd_valid;
    word_t     mem_fwd_data;
    logic      wb_we;
    reg_addr_t wb_dest;
    word_t     wb_data;

    // stage ports share their names with the nets above
    fetch_stage #(.reset_pc(reset_pc)) i_fetch (.*);

    decode_stage i_decode (.*);

    operand_bypass i_bypass (.*);

    execute_stage i_execute (.*);

    mem_wb_stage i_mem_wb (.*);

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (wb_we),
        .waddr  (wb_dest),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  word_t     inst,
    input  word_t     id_pc,
    input  logic      id_valid,
    input  word_t     rj_value,
    input  word_t     rkd_value,
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    output reg_addr_t id_dest,
    output logic      used_rj,
    output logic      used_rkd,
    output logic      id_writes,
    output logic      br_taken,
    output word_t     br_target,
    output alu_op_t   alu_op,
    output word_t     alu_src1,
    output word_t     alu_src2,
    output word_t     store_data,
    output logic      mem_read,
    output logic      mem_write
);

    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t rk;
    logic      is_3r;
    logic      is_shift;
    logic      inst_add_w;
    logic      inst_sub_w;
    logic      inst_slt;
    logic      inst_sltu;
    logic      inst_and;
    logic      inst_or;
    logic      inst_nor;
    logic      inst_xor;
    logic      inst_slli_w;
    logic      inst_srli_w;
    logic      inst_srai_w;
    logic      inst_addi_w;
    logic      inst_lu12i_w;
    logic      inst_ld_w;
    logic      inst_st_w;
    logic      inst_beq;
    logic      inst_bne;
    logic      inst_b;
    logic      inst_bl;
    logic      inst_jirl;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      rj_eq_rd;
    word_t     imm;
    word_t     offs16;
    word_t     offs26;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign is_3r    = inst[31:26] == op_alu && inst[25:22] == 4'h0 && inst[21:20] == 2'h1;
    assign is_shift = inst[31:26] == op_alu && inst[25:22] == 4'h1 && inst[21:20] == 2'h0;

    assign inst_add_w   = is_3r && inst[19:15] == 5'h00;
    assign inst_sub_w   = is_3r && inst[19:15] == 5'h02;
    assign inst_slt     = is_3r && inst[19:15] == 5'h04;
    assign inst_sltu    = is_3r && inst[19:15] == 5'h05;
    assign inst_nor     = is_3r && inst[19:15] == 5'h08;
    assign inst_and     = is_3r && inst[19:15] == 5'h09;
    assign inst_or      = is_3r && inst[19:15] == 5'h0a;
    assign inst_xor     = is_3r && inst[19:15] == 5'h0b;
    assign inst_slli_w  = is_shift && inst[19:15] == 5'h01;
    assign inst_srli_w  = is_shift && inst[19:15] == 5'h09;
    assign inst_srai_w  = is_shift && inst[19:15] == 5'h11;
    assign inst_addi_w  = inst[31:26] == op_alu && inst[25:22] == 4'ha;
    assign inst_lu12i_w = inst[31:26] == op_lu12i && !inst[25];
    assign inst_ld_w    = inst[31:26] == op_mem && inst[25:22] == 4'h2;
    assign inst_st_w    = inst[31:26] == op_mem && inst[25:22] == 4'h6;
    assign inst_jirl    = inst[31:26] == op_jirl;
    assign inst_b       = inst[31:26] == op_b;
    assign inst_bl      = inst[31:26] == op_bl;
    assign inst_beq     = inst[31:26] == op_beq;
    assign inst_bne     = inst[31:26] == op_bne;

    always_comb begin
        alu_op = '0;
        alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                         | inst_jirl | inst_bl;
        alu_op[alu_sub]  = inst_sub_w;
        alu_op[alu_slt]  = inst_slt;
        alu_op[alu_sltu] = inst_sltu;
        alu_op[alu_and]  = inst_and;
        alu_op[alu_nor]  = inst_nor;
        alu_op[alu_or]   = inst_or;
        alu_op[alu_xor]  = inst_xor;
        alu_op[alu_sll]  = inst_slli_w;
        alu_op[alu_srl]  = inst_srli_w;
        alu_op[alu_sra]  = inst_srai_w;
        alu_op[alu_lui]  = inst_lu12i_w;
    end

    // link value is pc + 4
    assign imm = (inst_jirl | inst_bl) ? 32'd4 :
                 inst_lu12i_w          ? {inst[24:5], 12'b0} :
                 is_shift              ? {27'b0, inst[14:10]} :
                                         {{20{inst[21]}}, inst[21:10]};

    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = is_shift | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w
                       | inst_jirl | inst_bl;

    // branches and stores read rd as the second source
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;

    assign used_rj  = id_valid && (is_3r | is_shift | inst_addi_w | inst_ld_w | inst_st_w
                                   | inst_beq | inst_bne | inst_jirl);
    assign used_rkd = id_valid && (is_3r | inst_beq | inst_bne | inst_st_w);

    assign id_dest   = inst_bl ? link_reg : rd;
    assign id_writes = id_valid && (is_3r | is_shift | inst_addi_w | inst_lu12i_w | inst_ld_w
                                    | inst_jirl | inst_bl);

    assign rj_eq_rd  = rj_value == rkd_value;
    assign br_taken  = id_valid && (inst_beq && rj_eq_rd || inst_bne && !rj_eq_rd
                                    || inst_b || inst_bl || inst_jirl);
    assign br_target = inst_jirl ? rj_value + offs16 :
                       (inst_b | inst_bl) ? id_pc + offs26 : id_pc + offs16;

    assign alu_src1   = src1_is_pc ? id_pc : rj_value;
    assign alu_src2   = src2_is_imm ? imm : rkd_value;
    assign store_data = rkd_value;
    assign mem_read   = inst_ld_w;
    assign mem_write  = inst_st_w;

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      id_ready,
    input  logic      id_valid,
    input  word_t     id_pc,
    input  reg_addr_t id_dest,
    input  logic      id_writes,
    input  alu_op_t   alu_op,
    input  word_t     alu_src1,
    input  word_t     alu_src2,
    input  word_t     store_data,
    input  logic      mem_read,
    input  logic      mem_write,
    output logic      data_sram_en,
    output logic      data_sram_we,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    output reg_addr_t ex_fwd_dest,
    output logic      ex_fwd_valid,
    output word_t     ex_fwd_data,
    output word_t     mem_pc,
    output reg_addr_t mem_dest,
    output word_t     mem_result,
    output logic      mem_writes,
    output logic      mem_is_load,
    output logic      mem_valid
);

    logic      ex_valid;
    word_t     ex_pc;
    reg_addr_t ex_dest;
    logic      ex_writes;
    alu_op_t   ex_alu_op;
    word_t     ex_src1;
    word_t     ex_src2;
    word_t     ex_store_data;
    logic      ex_load;
    logic      ex_store;
    word_t     alu_result;

    alu i_alu (
        .alu_op     (ex_alu_op),
        .alu_src1   (ex_src1),
        .alu_src2   (ex_src2),
        .alu_result (alu_result)
    );

    assign data_sram_en    = ex_valid && (ex_load || ex_store);
    assign data_sram_we    = ex_valid && ex_store;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = ex_store_data;

    // a load claims its register here but has no data yet
    assign ex_fwd_dest  = (ex_valid && ex_writes) ? ex_dest : zero_reg;
    assign ex_fwd_valid = ex_valid && ex_writes && !ex_load;
    assign ex_fwd_data  = alu_result;

    // stalled or empty decode issues a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            ex_valid  <= id_valid && id_ready;
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= id_pc;
        ex_dest       <= id_dest;
        ex_writes     <= id_writes;
        ex_alu_op     <= alu_op;
        ex_src1       <= alu_src1;
        ex_src2       <= alu_src2;
        ex_store_data <= store_data;
        ex_load       <= mem_read;
        ex_store      <= mem_write;
        mem_pc        <= ex_pc;
        mem_dest      <= ex_dest;
        mem_result    <= alu_result;
        mem_writes    <= ex_writes;
        mem_is_load   <= ex_load;
    end

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'h1c00_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t inst_sram_rdata,
    input  logic  id_ready,
    input  logic  br_taken,
    input  word_t br_target,
    output word_t inst_sram_addr,
    output word_t id_pc,
    output logic  id_valid,
    output word_t inst
);

    word_t pc;
    word_t next_pc;
    word_t inst_hold;
    logic  use_hold;
    logic  redirect;

    // br_taken already carries the decode valid
    assign redirect = br_taken && id_ready;
    assign next_pc  = redirect ? br_target : pc + 32'd4;

    assign inst_sram_addr = pc;

    // sram output moves on during a stall, so decode sees the saved copy
    assign inst = use_hold ? inst_hold : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= reset_pc;
            id_valid <= 1'b0;
            use_hold <= 1'b0;
        end else begin
            use_hold <= !id_ready;
            if (id_ready) begin
                pc       <= next_pc;
                id_valid <= !redirect;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_ready) begin
            id_pc <= pc;
        end else begin
            inst_hold <= inst;
        end
    end

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  word_t     data_sram_rdata,
    input  word_t     mem_pc,
    input  reg_addr_t mem_dest,
    input  word_t     mem_result,
    input  logic      mem_writes,
    input  logic      mem_is_load,
    input  logic      mem_valid,
    output reg_addr_t mem_fwd_dest,
    output logic      mem_fwd_valid,
    output word_t     mem_fwd_data,
    output logic      wb_we,
    output reg_addr_t wb_dest,
    output word_t     wb_data,
    output word_t     debug_wb_pc,
    output logic      debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    word_t mem_data;
    word_t wb_pc;

    // sram data arrives one cycle after the execute request
    assign mem_data = mem_is_load ? data_sram_rdata : mem_result;

    assign mem_fwd_dest  = mem_dest;
    assign mem_fwd_valid = mem_valid && mem_writes;
    assign mem_fwd_data  = mem_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_valid && mem_writes;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= mem_pc;
        wb_dest <= mem_dest;
        wb_data <= mem_data;
    end

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_we    = wb_we;
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// File: design/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rf_raddr1,
    input  reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  logic      used_rj,
    input  logic      used_rkd,
    input  reg_addr_t id_dest,
    input  logic      id_writes,
    input  reg_addr_t ex_fwd_dest,
    input  logic      ex_fwd_valid,
    input  word_t     ex_fwd_data,
    input  reg_addr_t mem_fwd_dest,
    input  logic      mem_fwd_valid,
    input  word_t     mem_fwd_data,
    input  logic      wb_we,
    input  reg_addr_t wb_dest,
    input  word_t     wb_data,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      id_ready
);

    logic [31:0] pending;
    logic [31:0] set_mask;
    logic [31:0] clr_mask;

    // ex_fwd_dest is r0 unless execute holds a register write,
    // which hides any older writer of the same register
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_data);
        if (addr == zero_reg)
            return rf_data;
        if (ex_fwd_dest == addr)
            return ex_fwd_data;
        if (mem_fwd_valid && mem_fwd_dest == addr)
            return mem_fwd_data;
        if (wb_we && wb_dest == addr)
            return wb_data;
        return rf_data;
    endfunction

    function automatic logic blocked(input reg_addr_t addr, input logic used);
        logic mem_hit;
        logic wb_hit;
        mem_hit = mem_fwd_valid && mem_fwd_dest == addr;
        wb_hit  = wb_we && wb_dest == addr;
        if (!used || addr == zero_reg)
            return 1'b0;
        // load still in execute
        if (ex_fwd_dest == addr)
            return !ex_fwd_valid;
        return pending[addr] && !mem_hit && !wb_hit;
    endfunction

    always_comb begin
        rj_value  = pick(rf_raddr1, rf_rdata1);
        rkd_value = pick(rf_raddr2, rf_rdata2);
        id_ready  = !(blocked(rf_raddr1, used_rj) || blocked(rf_raddr2, used_rkd));
    end

    assign set_mask = (id_writes && id_ready && id_dest != zero_reg) ? 32'd1 << id_dest : '0;
    assign clr_mask = wb_we ? 32'd1 << wb_dest : '0;

    // a new writer wins over a retiring one
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == zero_reg) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == zero_reg) ? '0 : regs[raddr2];

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu_tb -o cpu_sim

out=$(./obj_dir/cpu_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: sim.f
design/cpu_pkg.sv
design/alu.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/operand_bypass.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
tests/cpu_tb.sv

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam word_t reset_pc       = 32'h1c00_0000;
    localparam int    prog_len       = 200;
    localparam int    mem_words      = 64;
    localparam int    timeout_cycles = 10 * prog_len + 100;

    // 3R and shift kinds are contiguous
    localparam int k_add   = 0;
    localparam int k_sub   = 1;
    localparam int k_slt   = 2;
    localparam int k_sltu  = 3;
    localparam int k_and   = 4;
    localparam int k_or    = 5;
    localparam int k_nor   = 6;
    localparam int k_xor   = 7;
    localparam int k_slli  = 8;
    localparam int k_srli  = 9;
    localparam int k_srai  = 10;
    localparam int k_addi  = 11;
    localparam int k_lu12i = 12;
    localparam int k_ld    = 13;
    localparam int k_st    = 14;
    localparam int k_beq   = 15;
    localparam int k_bne   = 16;
    localparam int k_b     = 17;
    localparam int k_bl    = 18;
    localparam int k_jirl  = 19;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    word_t     inst_sram_addr;
    word_t     inst_sram_rdata = '0;
    logic      data_sram_en;
    logic      data_sram_we;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata = '0;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    word_t seed = 32'h28a6;
    int    kind  [prog_len];
    int    f_rd  [prog_len];
    int    f_rj  [prog_len];
    int    f_rk  [prog_len];
    int    f_imm [prog_len];
    word_t imem  [prog_len];
    word_t dmem  [mem_words];
    word_t exp_pc [$];
    int    exp_reg [$];
    word_t exp_val [$];
    word_t store_addr [$];
    word_t store_data [$];
    int    total_wb;
    int    matched = 0;
    int    cycles = 0;

    cpu_top #(.reset_pc(reset_pc)) i_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #50 clk = ~clk;

    function automatic word_t lcg(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int n);
        seed = lcg(seed);
        return int'(seed >> 8) % n;
    endfunction

    // small register pool keeps dependences dense
    // r7 is left for jirl
    function automatic int rand_reg();
        return rand_below(7);
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f96;
    endfunction

    function automatic word_t encode(input int idx);
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        word_t      imm;
        word_t      off;
        word_t      r3;
        word_t      i12;
        rd  = 5'(f_rd[idx]);
        rj  = 5'(f_rj[idx]);
        rk  = 5'(f_rk[idx]);
        imm = word_t'(f_imm[idx]);
        off = word_t'(f_imm[idx] - idx);
        r3  = {17'b0, rk, rj, rd};
        i12 = {10'b0, imm[11:0], rj, rd};
        case (kind[idx])
            k_add:   return 32'h0010_0000 | r3;
            k_sub:   return 32'h0011_0000 | r3;
            k_slt:   return 32'h0012_0000 | r3;
            k_sltu:  return 32'h0012_8000 | r3;
            k_nor:   return 32'h0014_0000 | r3;
            k_and:   return 32'h0014_8000 | r3;
            k_or:    return 32'h0015_0000 | r3;
            k_xor:   return 32'h0015_8000 | r3;
            k_slli:  return 32'h0040_8000 | {17'b0, imm[4:0], rj, rd};
            k_srli:  return 32'h0044_8000 | {17'b0, imm[4:0], rj, rd};
            k_srai:  return 32'h0048_8000 | {17'b0, imm[4:0], rj, rd};
            k_addi:  return 32'h0280_0000 | i12;
            k_lu12i: return 32'h1400_0000 | {7'b0, imm[19:0], rd};
            k_ld:    return 32'h2880_0000 | i12;
            k_st:    return 32'h2980_0000 | i12;
            k_jirl:  return 32'h4c00_0000 | {6'b0, imm[15:0], rj, rd};
            k_b:     return 32'h5000_0000 | {6'b0, off[15:0], off[25:16]};
            k_bl:    return 32'h5400_0000 | {6'b0, off[15:0], off[25:16]};
            k_beq:   return 32'h5800_0000 | {6'b0, off[15:0], rj, rd};
            default: return 32'h5c00_0000 | {6'b0, off[15:0], rj, rd};
        endcase
    endfunction

    // branch imm holds the absolute target index
    task automatic place(input int idx, input int k, input int rd, input int rj,
                         input int rk, input int imm);
        kind[idx]  = k;
        f_rd[idx]  = rd;
        f_rj[idx]  = rj;
        f_rk[idx]  = rk;
        f_imm[idx] = imm;
        imem[idx]  = encode(idx);
    endtask

    task automatic build_program();
        int i;
        int n;
        int pick;
        int r;
        int tgt;
        int far;
        i   = 0;
        far = 0;
        for (r = 1; r <= 7; r++) begin
            place(i, k_addi, r, 0, 0, rand_below(4096) - 2048);
            i++;
        end
        while (i < prog_len - 1) begin
            pick = rand_below(16);
            n    = 1;
            tgt  = i + 2 + rand_below(3);
            if (tgt > prog_len - 1)
                tgt = prog_len - 1;
            if (pick == 8 && i + 3 < prog_len - 1) begin
                // store then reload the same word and use it at once
                tgt = rand_below(mem_words) * 4;
                r   = 1 + rand_below(6);
                place(i, k_st, rand_reg(), 0, 0, tgt);
                place(i + 1, k_ld, r, 0, 0, tgt);
                place(i + 2, k_add, rand_reg(), r, rand_reg(), 0);
                n = 3;
            end else if (pick == 12 && i + 3 < prog_len - 1 && far <= i) begin
                // no earlier jump may land past the lu12i of this group
                tgt = i + 3 + rand_below(3);
                if (tgt > prog_len - 1)
                    tgt = prog_len - 1;
                place(i, k_lu12i, 7, 0, 0, int'(reset_pc >> 12));
                place(i + 1, k_addi, 7, 7, 0, tgt * 4);
                place(i + 2, k_jirl, rand_reg(), 7, 0, 0);
                far = tgt;
                n   = 3;
            end else if (pick == 5) begin
                place(i, k_slli + rand_below(3), rand_reg(), rand_reg(), 0, rand_below(32));
            end else if (pick == 6) begin
                place(i, k_addi, rand_reg(), rand_reg(), 0, rand_below(4096) - 2048);
            end else if (pick == 7) begin
                place(i, k_lu12i, rand_reg(), 0, 0, rand_below(1 << 20));
            end else if (pick == 9) begin
                place(i, k_ld, rand_reg(), 0, 0, rand_below(mem_words) * 4);
            end else if (pick == 10) begin
                r = rand_reg();
                place(i, k_beq + rand_below(2), rand_below(2) ? r : rand_reg(), r, 0, tgt);
                if (tgt > far)
                    far = tgt;
            end else if (pick == 11) begin
                place(i, k_b + rand_below(2), 0, 0, 0, tgt);
                if (tgt > far)
                    far = tgt;
            end else begin
                place(i, rand_below(8), rand_reg(), rand_reg(), rand_reg(), 0);
            end
            i += n;
        end
        place(prog_len - 1, k_b, 0, 0, 0, prog_len - 1);
    endtask

    // ISA model that fills the expected queues
    function automatic void run_reference();
        word_t regs [32];
        word_t mem [mem_words];
        word_t a;
        word_t b;
        word_t res;
        word_t pc;
        word_t addr;
        logic  wr;
        int    idx;
        int    nxt;
        int    steps;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        for (int m = 0; m < mem_words; m++)
            mem[m] = fill_word(word_t'(m * 4));
        idx   = 0;
        steps = 0;
        while (idx < prog_len - 1 && steps < prog_len + 10) begin
            pc   = reset_pc + word_t'(idx * 4);
            a    = regs[f_rj[idx]];
            b    = regs[f_rk[idx]];
            addr = a + word_t'(f_imm[idx]);
            nxt  = idx + 1;
            wr   = 1'b1;
            res  = '0;
            case (kind[idx])
                k_add:   res = a + b;
                k_sub:   res = a - b;
                k_slt:   res = {31'b0, $signed(a) < $signed(b)};
                k_sltu:  res = {31'b0, a < b};
                k_and:   res = a & b;
                k_or:    res = a | b;
                k_nor:   res = ~(a | b);
                k_xor:   res = a ^ b;
                k_slli:  res = a << f_imm[idx];
                k_srli:  res = a >> f_imm[idx];
                k_srai:  res = word_t'($signed(a) >>> f_imm[idx]);
                k_addi:  res = addr;
                k_lu12i: res = word_t'(f_imm[idx]) << 12;
                k_ld:    res = mem[addr[7:2]];
                k_st: begin
                    wr = 1'b0;
                    mem[addr[7:2]] = regs[f_rd[idx]];
                    store_addr.push_back(addr);
                    store_data.push_back(regs[f_rd[idx]]);
                end
                k_beq, k_bne: begin
                    wr = 1'b0;
                    if ((a == regs[f_rd[idx]]) == (kind[idx] == k_beq))
                        nxt = f_imm[idx];
                end
                k_b: begin
                    wr  = 1'b0;
                    nxt = f_imm[idx];
                end
                k_bl: begin
                    res = pc + 32'd4;
                    nxt = f_imm[idx];
                end
                default: begin
                    res = pc + 32'd4;
                    nxt = int'((a + (word_t'(f_imm[idx]) << 2) - reset_pc) >> 2);
                end
            endcase
            // bl always links through r1
            if (kind[idx] == k_bl)
                f_rd[idx] = 1;
            if (wr && f_rd[idx] != 0) begin
                regs[f_rd[idx]] = res;
                exp_pc.push_back(pc);
                exp_reg.push_back(f_rd[idx]);
                exp_val.push_back(res);
            end
            idx = nxt;
            steps++;
        end
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t off;
        off = addr - reset_pc;
        if (off < word_t'(prog_len * 4))
            return imem[int'(off >> 2)];
        return '0;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_writeback();
        word_t pc;
        int    rn;
        word_t val;
        if (exp_pc.size() == 0) begin
            stop_on_error("a register write-back appeared after the last expected one");
        end else begin
            pc  = exp_pc.pop_front();
            rn  = exp_reg.pop_front();
            val = exp_val.pop_front();
            assert (debug_wb_pc == pc) else stop_on_error(
                $sformatf("Fail debug_wb_pc: got %h, expected %h", debug_wb_pc, pc));
            assert (debug_wb_rf_wnum == reg_addr_t'(rn)) else stop_on_error(
                $sformatf("Fail debug_wb_rf_wnum: got %h, expected %h", debug_wb_rf_wnum,
                          reg_addr_t'(rn)));
            assert (debug_wb_rf_wdata == val) else stop_on_error(
                $sformatf("Fail debug_wb_rf_wdata: got %h, expected %h", debug_wb_rf_wdata,
                          val));
            matched++;
        end
    endtask

    task automatic check_store();
        word_t addr;
        word_t data;
        if (store_addr.size() == 0) begin
            stop_on_error("a store request appeared after the last expected store");
        end else begin
            addr = store_addr.pop_front();
            data = store_data.pop_front();
            assert (data_sram_addr == addr) else stop_on_error(
                $sformatf("Fail data_sram_addr: got %h, expected %h", data_sram_addr, addr));
            assert (data_sram_wdata == data) else stop_on_error(
                $sformatf("Fail data_sram_wdata: got %h, expected %h", data_sram_wdata, data));
        end
    endtask

    // one-cycle synchronous SRAMs
    always @(posedge clk) begin
        inst_sram_rdata <= fetch_word(inst_sram_addr);
        if (data_sram_en) begin
            if (data_sram_we)
                dmem[data_sram_addr[7:2]] <= data_sram_wdata;
            data_sram_rdata <= dmem[data_sram_addr[7:2]];
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset) begin
            assert (!data_sram_en && !debug_wb_rf_we) else stop_on_error(
                "data request or register write-back seen while in reset");
        end else begin
            assert (data_sram_en || !data_sram_we) else stop_on_error(
                "data_sram_we went high without data_sram_en");
            if (data_sram_en && data_sram_we)
                check_store();
            // writes to r0 leave no architectural trace
            if (debug_wb_rf_we && debug_wb_rf_wnum != zero_reg)
                check_writeback();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            stop_on_error($sformatf("timeout: trace incomplete after %0d cycles", cycles));
    end

    initial begin
        for (int m = 0; m < mem_words; m++)
            dmem[m] = fill_word(word_t'(m * 4));
        build_program();
        run_reference();
        total_wb = exp_pc.size();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (inst_sram_addr == reset_pc) else stop_on_error(
            $sformatf("Fail inst_sram_addr: got %h, expected %h", inst_sram_addr, reset_pc));
        while (matched < total_wb)
            @(posedge clk);
        // let the final loop spin so stray write-backs or stores show up
        repeat (20) @(posedge clk);
        if (store_addr.size() != 0) begin
            $display("expected stores never appeared");
            $display("STATUS: FAIL");
            $fatal(1, "simulation stopped with unchecked stores");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule
